//--- hw/isaPkg.sv
`default_nettype none

package isaPkg;

    // Datapath sizes
    localparam int dataWidth = 32;
    localparam int regCount = 16;
    localparam int regIdxWidth = $clog2(regCount);

    typedef logic [regIdxWidth-1:0] regIdxT;

    // Code 0 and every code not listed here decode as halt
    typedef enum logic [4:0] {
        opLd   = 5'h01,
        opSt   = 5'h02,
        opAdd  = 5'h03,
        opSub  = 5'h04,
        opAnd  = 5'h05,
        opOr   = 5'h06,
        opAddi = 5'h07,
        opAndi = 5'h08,
        opOri  = 5'h09,
        opOut  = 5'h0a,
        opHalt = 5'h1f
    } opcodeT;

    // Instruction word fields
    localparam int opcodeMsb = 31;
    localparam int opcodeLsb = 27;
    localparam int raMsb = 26;
    localparam int raLsb = 23;
    localparam int rbMsb = 22;
    localparam int rbLsb = 19;
    localparam int rcMsb = 18;
    localparam int rcLsb = 15;
    localparam int immMsb = 18;
    localparam int immLsb = 0;
    localparam int immWidth = immMsb - immLsb + 1;

endpackage

`default_nettype wire

//--- hw/memBusPkg.sv
`default_nettype none

package memBusPkg;

    // Word addressed, so one address per 32-bit word
    localparam int addrWidth = 8;
    localparam int memDepth = 1 << addrWidth;

    typedef logic [addrWidth-1:0] addrT;

    // Requesters that share the memory
    typedef enum logic {
        clientLoader = 1'b0,
        clientCore   = 1'b1
    } clientT;

endpackage

`default_nettype wire

//--- hw/memPortIf.sv
`default_nettype none

interface memPortIf;
    import isaPkg::*;
    import memBusPkg::*;

    logic                 valid;
    logic                 ready;
    logic                 write;
    addrT                 addr;
    logic [dataWidth-1:0] wdata;
    logic [dataWidth-1:0] rdata;
    // One-cycle read response
    logic                 rvalid;

    modport requester (
        output valid, write, addr, wdata,
        input  ready, rdata, rvalid
    );

    modport responder (
        input  valid, write, addr, wdata,
        output ready, rdata, rvalid
    );

endinterface

`default_nettype wire

//--- hw/memArbiter.sv
`default_nettype none

module memArbiter (
    input logic         Clock,
    input logic         rst,
    memPortIf.responder loaderPort,
    memPortIf.responder corePort,
    memPortIf.requester memPort
);
    import memBusPkg::*;

    // Owner of the last accepted request
    clientT grant;
    clientT winner;
    logic   pending;
    logic   memFree;
    logic   xfer;

    // Memory is busy only while a read waits for its data
    assign memFree = !pending;

    // Fixed priority, the loader wins a tie
    assign winner = loaderPort.valid ? clientLoader : clientCore;

    // Request path passes straight through to memory
    always_comb begin
        memPort.valid = memFree && (loaderPort.valid || corePort.valid);
        if (winner == clientLoader) begin
            memPort.write = loaderPort.write;
            memPort.addr  = loaderPort.addr;
            memPort.wdata = loaderPort.wdata;
        end else begin
            memPort.write = corePort.write;
            memPort.addr  = corePort.addr;
            memPort.wdata = corePort.wdata;
        end
    end

    assign xfer = memPort.valid && memPort.ready;

    // Losing side is held off by a low ready
    assign loaderPort.ready = memFree && (winner == clientLoader) && loaderPort.valid
                              && memPort.ready;
    assign corePort.ready = memFree && (winner == clientCore) && corePort.valid
                            && memPort.ready;

    // Read data is shared, the strobe goes only to the owner
    assign loaderPort.rdata = memPort.rdata;
    assign corePort.rdata = memPort.rdata;
    assign loaderPort.rvalid = memPort.rvalid && pending && (grant == clientLoader);
    assign corePort.rvalid = memPort.rvalid && pending && (grant == clientCore);

    always_ff @(posedge Clock) begin
        if (rst) begin
            grant   <= clientLoader;
            pending <= 1'b0;
        end else if (xfer) begin
            grant   <= winner;
            // Writes give no response, so they free memory at once
            pending <= !memPort.write;
        end else if (memPort.rvalid) begin
            pending <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/mainMemory.sv
`default_nettype none

module mainMemory (
    input logic         Clock,
    memPortIf.responder port
);
    import isaPkg::*;
    import memBusPkg::*;

    logic [dataWidth-1:0] mem [memDepth];
    logic                 writeXfer;
    logic                 readXfer;

    // Never stalls
    assign port.ready = 1'b1;

    assign writeXfer = port.valid && port.ready && port.write;
    assign readXfer = port.valid && port.ready && !port.write;

    always_ff @(posedge Clock) begin
        if (writeXfer) begin
            mem[port.addr] <= port.wdata;
        end
        if (readXfer) begin
            port.rdata <= mem[port.addr];
        end
        // Response strobe one cycle after the read is accepted
        port.rvalid <= readXfer;
    end

endmodule

`default_nettype wire

//--- hw/registerFile.sv
`default_nettype none

module registerFile (
    input  logic                       Clock,
    input  logic                       rst,
    input  isaPkg::regIdxT             readIdxA,
    input  isaPkg::regIdxT             readIdxB,
    output logic [isaPkg::dataWidth-1:0] readDataA,
    output logic [isaPkg::dataWidth-1:0] readDataB,
    input  logic                       writeEn,
    input  isaPkg::regIdxT             writeIdx,
    input  logic [isaPkg::dataWidth-1:0] writeData
);
    import isaPkg::*;

    logic [dataWidth-1:0] regs [regCount];

    // R0 is hardwired to zero so it can serve as a zero base
    assign readDataA = (readIdxA == '0) ? '0 : regs[readIdxA];
    assign readDataB = (readIdxB == '0) ? '0 : regs[readIdxB];

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeIdx != '0)) begin
            regs[writeIdx] <= writeData;
        end
    end

endmodule

`default_nettype wire

//--- hw/alu.sv
`default_nettype none

module alu (
    input  isaPkg::opcodeT               op,
    input  logic [isaPkg::dataWidth-1:0] operandA,
    input  logic [isaPkg::dataWidth-1:0] operandB,
    output logic [isaPkg::dataWidth-1:0] result
);
    import isaPkg::*;

    always_comb begin
        case (op)
            // Loads and stores use the adder for base plus offset
            opAdd, opAddi, opLd, opSt: begin
                result = operandA + operandB;
            end
            opSub: begin
                result = operandA - operandB;
            end
            opAnd, opAndi: begin
                result = operandA & operandB;
            end
            opOr, opOri: begin
                result = operandA | operandB;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/controlSequencer.sv
`default_nettype none

module controlSequencer (
    input  logic                         Clock,
    input  logic                         rst,
    input  logic                         start,
    memPortIf.requester                  memPort,
    output isaPkg::regIdxT               readIdxA,
    output isaPkg::regIdxT               readIdxB,
    input  logic [isaPkg::dataWidth-1:0] readDataA,
    input  logic [isaPkg::dataWidth-1:0] readDataB,
    output logic                         writeEn,
    output isaPkg::regIdxT               writeIdx,
    output logic [isaPkg::dataWidth-1:0] writeData,
    output isaPkg::opcodeT               aluOp,
    output logic [isaPkg::dataWidth-1:0] aluA,
    output logic [isaPkg::dataWidth-1:0] aluB,
    input  logic [isaPkg::dataWidth-1:0] aluResult,
    output logic                         outValid,
    input  logic                         outReady,
    output logic [isaPkg::dataWidth-1:0] outData,
    output logic                         halted
);
    import isaPkg::*;
    import memBusPkg::*;

    typedef enum logic [3:0] {
        sIdle, sFetch, sFetchWait, sExec, sMemReq, sMemWait, sWrite, sOut, sHalt
    } stateT;

    stateT                state;
    addrT                 pc;
    logic [dataWidth-1:0] ir;
    // Y holds the ra value for stores and out, Z the ALU result
    logic [dataWidth-1:0] y;
    logic [dataWidth-1:0] z;
    opcodeT               op;
    regIdxT               ra;
    regIdxT               rb;
    regIdxT               rc;
    logic [dataWidth-1:0] immExt;
    logic                 regRegOp;
    logic                 memXfer;

    // Instruction decode
    assign op = opcodeT'(ir[opcodeMsb:opcodeLsb]);
    assign ra = ir[raMsb:raLsb];
    assign rb = ir[rbMsb:rbLsb];
    assign rc = ir[rcMsb:rcLsb];
    assign immExt = {{(dataWidth - immWidth){ir[immMsb]}}, ir[immMsb:immLsb]};
    assign regRegOp = op inside {opAdd, opSub, opAnd, opOr};

    // Port B reads ra when it is a source, otherwise rc
    assign readIdxA = rb;
    assign readIdxB = (op == opSt || op == opOut) ? ra : rc;

    assign aluOp = op;
    assign aluA = readDataA;
    assign aluB = regRegOp ? readDataB : immExt;

    // Memory requests for fetch and for load/store
    assign memPort.valid = (state == sFetch) || (state == sMemReq);
    assign memPort.write = (state == sMemReq) && (op == opSt);
    assign memPort.addr = (state == sFetch) ? pc : z[addrWidth-1:0];
    assign memPort.wdata = y;
    assign memXfer = memPort.valid && memPort.ready;

    // Writeback from the ALU or from load data
    assign writeEn = (state == sWrite) || ((state == sMemWait) && memPort.rvalid);
    assign writeIdx = ra;
    assign writeData = (state == sMemWait) ? memPort.rdata : z;

    assign outValid = (state == sOut);
    assign outData = y;
    assign halted = (state == sIdle) || (state == sHalt);

    always_ff @(posedge Clock) begin
        if (rst) begin
            state <= sIdle;
            pc    <= '0;
        end else begin
            case (state)
                sIdle, sHalt: begin
                    if (start) begin
                        pc    <= '0;
                        state <= sFetch;
                    end
                end
                sFetch: begin
                    // Waits here while the loader holds memory
                    if (memXfer) begin
                        pc    <= pc + addrT'(1);
                        state <= sFetchWait;
                    end
                end
                sFetchWait: begin
                    if (memPort.rvalid) begin
                        state <= sExec;
                    end
                end
                sExec: begin
                    case (op)
                        opLd, opSt: state <= sMemReq;
                        opAdd, opSub, opAnd, opOr: state <= sWrite;
                        opAddi, opAndi, opOri: state <= sWrite;
                        opOut: state <= sOut;
                        default: state <= sHalt;
                    endcase
                end
                sMemReq: begin
                    if (memXfer) begin
                        state <= (op == opSt) ? sFetch : sMemWait;
                    end
                end
                sMemWait: begin
                    if (memPort.rvalid) begin
                        state <= sFetch;
                    end
                end
                sWrite: begin
                    state <= sFetch;
                end
                sOut: begin
                    // Back-pressure stalls here with outData held in Y
                    if (outReady) begin
                        state <= sFetch;
                    end
                end
                default: begin
                    state <= sIdle;
                end
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if ((state == sFetchWait) && memPort.rvalid) begin
            ir <= memPort.rdata;
        end
        if (state == sExec) begin
            y <= readDataB;
            z <= aluResult;
        end
    end

endmodule

`default_nettype wire

//--- hw/miniCpu.sv
`default_nettype none

module miniCpu (
    input  logic                         Clock,
    input  logic                         rst,
    input  logic                         start,
    input  logic                         loadValid,
    output logic                         loadReady,
    input  memBusPkg::addrT              loadAddr,
    input  logic [isaPkg::dataWidth-1:0] loadData,
    output logic                         outValid,
    input  logic                         outReady,
    output logic [isaPkg::dataWidth-1:0] outData,
    output logic                         halted
);
    import isaPkg::*;

    regIdxT               readIdxA;
    regIdxT               readIdxB;
    logic [dataWidth-1:0] readDataA;
    logic [dataWidth-1:0] readDataB;
    logic                 writeEn;
    regIdxT               writeIdx;
    logic [dataWidth-1:0] writeData;
    opcodeT               aluOp;
    logic [dataWidth-1:0] aluA;
    logic [dataWidth-1:0] aluB;
    logic [dataWidth-1:0] aluResult;

    memPortIf loaderBus ();
    memPortIf coreBus ();
    memPortIf memBus ();

    // Loader only writes
    assign loaderBus.valid = loadValid;
    assign loaderBus.write = 1'b1;
    assign loaderBus.addr = loadAddr;
    assign loaderBus.wdata = loadData;
    assign loadReady = loaderBus.ready;

    memArbiter memArbiter_inst (
        .Clock      (Clock),
        .rst        (rst),
        .loaderPort (loaderBus.responder),
        .corePort   (coreBus.responder),
        .memPort    (memBus.requester)
    );

    mainMemory mainMemory_inst (
        .Clock (Clock),
        .port  (memBus.responder)
    );

    registerFile registerFile_inst (
        .Clock     (Clock),
        .rst       (rst),
        .readIdxA  (readIdxA),
        .readIdxB  (readIdxB),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .writeEn   (writeEn),
        .writeIdx  (writeIdx),
        .writeData (writeData)
    );

    alu alu_inst (
        .op       (aluOp),
        .operandA (aluA),
        .operandB (aluB),
        .result   (aluResult)
    );

    controlSequencer controlSequencer_inst (
        .Clock     (Clock),
        .rst       (rst),
        .start     (start),
        .memPort   (coreBus.requester),
        .readIdxA  (readIdxA),
        .readIdxB  (readIdxB),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .writeEn   (writeEn),
        .writeIdx  (writeIdx),
        .writeData (writeData),
        .aluOp     (aluOp),
        .aluA      (aluA),
        .aluB      (aluB),
        .aluResult (aluResult),
        .outValid  (outValid),
        .outReady  (outReady),
        .outData   (outData),
        .halted    (halted)
    );

endmodule

`default_nettype wire

//--- tb/clockGen.sv
`default_nettype none

module clockGen #(
    parameter int period = 40
) (
    output logic Clock
);

    // Free-running clock, low for the first half period
    initial begin
        Clock = 1'b0;
        forever begin
            #(period / 2) Clock = ~Clock;
        end
    end

endmodule

`default_nettype wire

//--- tb/miniCpu_checker.sv
`default_nettype none

module miniCpu_checker (
    input logic Clock,
    input logic rst,
    input logic loaderReady,
    input logic coreReady,
    input logic grant,
    input logic pending,
    input logic memValid,
    input logic memReady,
    input logic memWrite,
    input logic memRvalid
);

    logic readXfer;

    assign readXfer = memValid && memReady && !memWrite;

    // Only one requester may be accepted per cycle
    readyExclusive: assert property (@(posedge Clock) disable iff (rst)
        !(loaderReady && coreReady))
        else $error("loader and core both see ready in the same cycle");

    // Owner of an outstanding read must not change
    grantHeld: assert property (@(posedge Clock) disable iff (rst)
        pending |=> $stable(grant))
        else $error("grant changed while a read was pending");

    // Read response comes exactly one cycle after the transfer
    rvalidAfterRead: assert property (@(posedge Clock) disable iff (rst)
        readXfer |=> memRvalid)
        else $error("no rvalid one cycle after a read transfer");

endmodule

bind memArbiter miniCpu_checker miniCpu_checker_inst (
    .Clock       (Clock),
    .rst         (rst),
    .loaderReady (loaderPort.ready),
    .coreReady   (corePort.ready),
    .grant       (grant),
    .pending     (pending),
    .memValid    (memPort.valid),
    .memReady    (memPort.ready),
    .memWrite    (memPort.write),
    .memRvalid   (memPort.rvalid)
);

`default_nettype wire

//--- tb/miniCpu_tb.sv
`default_nettype none

module miniCpu_tb;
    import isaPkg::*;

    localparam int clockPeriod = 40;
    localparam int resetCycles = 16;
    localparam int numRows = 8;
    localparam int cyclesPerRow = 400;

    logic        Clock;
    logic        rst;
    logic        start;
    logic        loadValid;
    logic        loadReady;
    logic [7:0]  loadAddr;
    logic [31:0] loadData;
    logic        outValid;
    logic        outReady;
    logic [31:0] outData;
    logic        halted;

    int          mismatchCount = 0;
    int          otherErrorCount = 0;
    logic [31:0] lcgState = 32'h9d77a5d2;
    logic [31:0] outWords [$];

    // Test table, operandB is the sign-extended immediate on immediate rows
    string       names [numRows] = '{
        "add", "sub", "and", "or", "addiNeg", "andiNeg", "oriNeg", "addiCarry"
    };
    opcodeT      ops [numRows] = '{
        opAdd, opSub, opAnd, opOr, opAddi, opAndi, opOri, opAddi
    };
    logic [31:0] operandA [numRows] = '{
        32'h12345678, 32'h00000010, 32'hf0f0f0f0, 32'h0f000f00,
        32'h00000064, 32'h12345678, 32'h00000001, 32'h7fffffff
    };
    logic [31:0] operandB [numRows] = '{
        32'h11111111, 32'h00000020, 32'h3c3c3c3c, 32'h00f000f0,
        32'hfffffffb, 32'hfffffff0, 32'hffffff00, 32'h00000001
    };
    logic [31:0] expected [numRows] = '{
        32'h23456789, 32'hfffffff0, 32'h30303030, 32'h0ff00ff0,
        32'h0000005f, 32'h12345670, 32'hffffff01, 32'h80000000
    };

    clockGen #(.period(clockPeriod)) clockGen_inst (
        .Clock (Clock)
    );

    miniCpu miniCpu_inst (
        .Clock     (Clock),
        .rst       (rst),
        .start     (start),
        .loadValid (loadValid),
        .loadReady (loadReady),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .outValid  (outValid),
        .outReady  (outReady),
        .outData   (outData),
        .halted    (halted)
    );

    // Opcode, ra, rb and the low 19 bits (rc or immediate)
    function automatic logic [31:0] encode(opcodeT op, logic [3:0] ra, logic [3:0] rb,
                                           logic [18:0] low);
        return {op, ra, rb, low};
    endfunction

    function automatic logic randomBit();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[31];
    endfunction

    // Holds the request until ready is seen mid low phase
    task automatic writeWord(input logic [7:0] addr, input logic [31:0] data);
        logic accepted;
        accepted = 1'b0;
        @(negedge Clock);
        loadValid = 1'b1;
        loadAddr  = addr;
        loadData  = data;
        while (!accepted) begin
            #(clockPeriod / 4);
            if (loadReady) begin
                accepted = 1'b1;
                @(posedge Clock);
            end else begin
                @(negedge Clock);
            end
        end
    endtask

    task automatic loadProgram(input int row);
        logic [31:0] prog [8];
        logic        isImm;
        isImm = ops[row] inside {opAddi, opAndi, opOri};
        prog[0] = encode(opLd, 4'd2, 4'd0, 19'd64);
        prog[1] = encode(opLd, 4'd3, 4'd0, 19'd65);
        if (isImm) begin
            prog[2] = encode(ops[row], 4'd1, 4'd2, operandB[row][18:0]);
        end else begin
            prog[2] = encode(ops[row], 4'd1, 4'd2, {4'd3, 15'd0});
        end
        prog[3] = encode(opSt, 4'd1, 4'd0, 19'd66);
        prog[4] = encode(opLd, 4'd4, 4'd0, 19'd66);
        prog[5] = encode(opOut, 4'd4, 4'd0, 19'd0);
        prog[6] = encode(opOut, 4'd2, 4'd0, 19'd0);
        prog[7] = encode(opHalt, 4'd0, 4'd0, 19'd0);
        for (int k = 0; k < 8; k++) begin
            writeWord(8'(k), prog[k]);
        end
        writeWord(8'd64, operandA[row]);
        writeWord(8'd65, operandB[row]);
        // Poison the store target so a lost store shows up
        writeWord(8'd66, ~expected[row]);
        @(negedge Clock);
        loadValid = 1'b0;
    endtask

    task automatic runProgram(input string name);
        logic        done;
        logic        stalled;
        logic [31:0] heldData;
        done     = 1'b0;
        stalled  = 1'b0;
        heldData = '0;
        outWords.delete();
        @(negedge Clock);
        start = 1'b1;
        @(negedge Clock);
        start = 1'b0;
        #(clockPeriod / 4);
        if (halted) begin
            otherErrorCount++;
            $display("%s: halted did not drop after start", name);
        end
        while (!done) begin
            @(negedge Clock);
            outReady = randomBit();
            #(clockPeriod / 4);
            if (halted) begin
                done = 1'b1;
            end else if (outValid) begin
                if (stalled && (outData != heldData)) begin
                    otherErrorCount++;
                    $display("%s: outData changed while the output was stalled", name);
                end
                if (outReady) begin
                    outWords.push_back(outData);
                    stalled = 1'b0;
                end else begin
                    stalled  = 1'b1;
                    heldData = outData;
                end
            end
        end
    endtask

    task automatic checkRow(input int row);
        if (outWords.size() != 2) begin
            mismatchCount++;
            $display("MISMATCH %s out word count: expected 2, actual %0d",
                     names[row], outWords.size());
        end
        if ((outWords.size() > 0) && (outWords[0] != expected[row])) begin
            mismatchCount++;
            $display("MISMATCH %s result: expected %h, actual %h",
                     names[row], expected[row], outWords[0]);
        end
        if ((outWords.size() > 1) && (outWords[1] != operandA[row])) begin
            mismatchCount++;
            $display("MISMATCH %s operand echo: expected %h, actual %h",
                     names[row], operandA[row], outWords[1]);
        end
    endtask

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        loadValid = 1'b0;
        loadAddr  = '0;
        loadData  = '0;
        outReady  = 1'b0;
        repeat (resetCycles) @(negedge Clock);
        rst = 1'b0;
        #(clockPeriod / 4);
        if (!halted) begin
            otherErrorCount++;
            $display("halted is low after reset");
        end

        for (int i = 0; i < numRows; i++) begin
            loadProgram(i);
            // A loader write competes with the running core
            fork
                begin
                    runProgram(names[i]);
                end
                begin
                    repeat (5) @(negedge Clock);
                    writeWord(8'd200, 32'ha5a50000 + 32'(i));
                    @(negedge Clock);
                    loadValid = 1'b0;
                end
            join
            checkRow(i);
        end

        $display("Mismatches: %0d, other errors: %0d", mismatchCount, otherErrorCount);
        if ((mismatchCount == 0) && (otherErrorCount == 0)) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        repeat (resetCycles + numRows * cyclesPerRow) @(posedge Clock);
        $display("Timeout: the tests did not finish in time");
        $display("Mismatches: %0d, other errors: %0d", mismatchCount, otherErrorCount);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hw/isaPkg.sv
hw/memBusPkg.sv
hw/memPortIf.sv
hw/memArbiter.sv
hw/mainMemory.sv
hw/registerFile.sv
hw/alu.sv
hw/controlSequencer.sv
hw/miniCpu.sv
tb/clockGen.sv
tb/miniCpu_checker.sv
tb/miniCpu_tb.sv

//--- Makefile
TOP := miniCpu_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
